//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_wave_channel -Mdir obj_dir -f sources.f
	./obj_dir/Vtb_wave_channel +verilator+error+limit+100 > sim.log 2>&1; \
		rc=$$?; cat sim.log; \
		if grep -q "test failed" sim.log; then exit 1; fi; \
		exit $$rc

clean:
	rm -rf obj_dir sim.log

//--- hdl/ch3_cfg.svh
`ifndef CH3_CFG_SVH
`define CH3_CFG_SVH

`define CH3_NR30 8'h1A // dac enable
`define CH3_NR31 8'h1B // length load
`define CH3_NR32 8'h1C // volume code
`define CH3_NR33 8'h1D // freq low byte
`define CH3_NR34 8'h1E // freq high, length enable, trigger

`define CH3_WAVE_BASE 8'h30 // 16 bytes of wave ram follow
`define CH3_LEN_MAX   256
`define CH3_TIMER_MAX 2047

`endif

//--- hdl/ch3_freq_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ch3_cfg.svh"

module ch3_freq_timer import ch3_pkg::*; (
	input  logic       cery_2mhz,
	input  logic       rst_n,
	input  logic       ch_on,
	input  logic       trigger,
	input  freq_t      freq,
	output logic       fetch_req,
	output wave_addr_t fetch_addr,
	output logic       nibble_lo
);

	freq_t     count;
	wave_pos_t pos, pos_next;
	logic      step;

	assign pos_next = pos + 5'd1; // wraps at 32
	assign step     = ch_on && !trigger && (count == freq_t'(`CH3_TIMER_MAX));

	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			count     <= '0;
			pos       <= '0;
			fetch_req <= 1'b0;
			nibble_lo <= 1'b0;
		end else begin
			fetch_req <= step;
			nibble_lo <= pos[0]; // lags pos to line up with the ram data
			if (trigger) begin
				count <= freq;
				pos   <= '0;
			end else if (step) begin
				count <= freq;
				pos   <= pos_next;
			end else if (ch_on) begin
				count <= count + 11'd1;
			end
		end
	end

	always_ff @(posedge cery_2mhz) begin
		if (step)
			fetch_addr <= pos_next[4:1];
	end

endmodule

`default_nettype wire

//--- hdl/ch3_length_ctr.sv
`timescale 1ns/1ps
`default_nettype none

`include "ch3_cfg.svh"

module ch3_length_ctr import ch3_pkg::*; (
	input  logic      cery_2mhz,
	input  logic      rst_n,
	input  logic      trigger,
	input  logic      dac_en,
	input  logic      length_en,
	input  logic      len_tick,
	input  logic      len_load,
	input  reg_data_t len_value,
	output logic      ch_on
);

	len_t len_cnt;

	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			len_cnt <= '0;
			ch_on   <= 1'b0;
		end else begin
			if (len_load)
				len_cnt <= len_t'(`CH3_LEN_MAX) - len_t'(len_value);
			else if (trigger && len_cnt == '0)
				len_cnt <= len_t'(`CH3_LEN_MAX);
			else if (len_tick && length_en && ch_on && len_cnt != '0)
				len_cnt <= len_cnt - 9'd1;

			if (!dac_en)
				ch_on <= 1'b0; // dac off kills the channel
			else if (trigger)
				ch_on <= 1'b1;
			else if (length_en && len_cnt == '0)
				ch_on <= 1'b0; // length expired
		end
	end

endmodule

`default_nettype wire

//--- hdl/ch3_output.sv
`timescale 1ns/1ps
`default_nettype none

module ch3_output import ch3_pkg::*; (
	input  logic      cery_2mhz,
	input  logic      rst_n,
	input  logic      ch_on,
	input  logic      fetch_data_valid,
	input  reg_data_t fetch_data,
	input  logic      nibble_lo,
	input  volume_t   volume,
	output sample_t   sample_out
);

	reg_data_t byte_q;
	logic      lo_q;
	sample_t   nib, scaled;

	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			byte_q <= '0;
			lo_q   <= 1'b0;
		end else if (fetch_data_valid) begin
			byte_q <= fetch_data;
			lo_q   <= nibble_lo;
		end
	end

	assign nib = lo_q ? byte_q[3:0] : byte_q[7:4]; // high nibble plays first

	always_comb begin
		case (volume)
			2'd0:    scaled = '0; // mute
			2'd1:    scaled = nib;
			2'd2:    scaled = nib >> 1;
			default: scaled = nib >> 2;
		endcase
	end

	assign sample_out = ch_on ? scaled : '0;

endmodule

`default_nettype wire

//--- hdl/ch3_pkg.sv
`default_nettype none

package ch3_pkg;

	typedef logic [7:0]  reg_addr_t; // low byte of cpu address
	typedef logic [7:0]  reg_data_t;
	typedef logic [10:0] freq_t; // period value
	typedef logic [4:0]  wave_pos_t; // 32 samples
	typedef logic [3:0]  wave_addr_t; // 16 bytes
	typedef logic [3:0]  sample_t;
	typedef logic [1:0]  volume_t;
	typedef logic [8:0]  len_t; // holds 0..256

	typedef enum logic [1:0] {
		idle,
		fetch, // fetch granted last cycle
		cpu_deferred // fetch granted last cycle, cpu access waiting
	} arb_state_t;

endpackage

`default_nettype wire

//--- hdl/ch3_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "ch3_cfg.svh"

module ch3_regs import ch3_pkg::*; (
	input  logic       cery_2mhz,
	input  logic       rst_n,
	input  reg_addr_t  addr,
	input  reg_data_t  d_in,
	input  logic       apu_wr,
	input  logic       cpu_rd,
	input  logic       wave_rd_valid,
	input  reg_data_t  wave_rd_data,
	output reg_data_t  d_out,
	output logic       rd_valid,
	output logic       wave_cpu_wr,
	output logic       wave_cpu_rd,
	output wave_addr_t wave_cpu_addr,
	output reg_data_t  wave_wdata,
	output logic       dac_en,
	output volume_t    volume,
	output freq_t      freq,
	output logic       length_en,
	output logic       trigger,
	output logic       len_load,
	output reg_data_t  len_value
);

	logic      is_wave;
	reg_data_t reg_rd;

	assign is_wave = ((addr & 8'hF0) == `CH3_WAVE_BASE);

	// wave accesses go straight on to the arbiter
	assign wave_cpu_wr   = apu_wr && is_wave;
	assign wave_cpu_rd   = cpu_rd && is_wave;
	assign wave_cpu_addr = addr[3:0];
	assign wave_wdata    = d_in;

	always_comb begin
		case (addr)
			`CH3_NR30: reg_rd = {dac_en, 7'h7F};
			`CH3_NR32: reg_rd = {1'b1, volume, 5'h1F};
			`CH3_NR34: reg_rd = {1'b1, length_en, 6'h3F};
			default:   reg_rd = 8'hFF; // NR31, NR33 are write only
		endcase
	end

	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			dac_en    <= 1'b0;
			volume    <= '0;
			freq      <= '0;
			length_en <= 1'b0;
			trigger   <= 1'b0;
			len_load  <= 1'b0;
			rd_valid  <= 1'b0;
		end else begin
			trigger  <= 1'b0;
			len_load <= 1'b0;
			rd_valid <= (cpu_rd && !is_wave) || wave_rd_valid;
			if (apu_wr) begin
				case (addr)
					`CH3_NR30: dac_en <= d_in[7];
					`CH3_NR31: len_load <= 1'b1;
					`CH3_NR32: volume <= d_in[6:5];
					`CH3_NR33: freq[7:0] <= d_in;
					`CH3_NR34: begin
						freq[10:8] <= d_in[2:0];
						length_en  <= d_in[6];
						trigger    <= d_in[7];
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge cery_2mhz) begin
		if (apu_wr && addr == `CH3_NR31)
			len_value <= d_in;
		if (cpu_rd && !is_wave)
			d_out <= reg_rd;
		else if (wave_rd_valid)
			d_out <= wave_rd_data; // returning wave byte
	end

endmodule

`default_nettype wire

//--- hdl/wave_channel.sv
`timescale 1ns/1ps
`default_nettype none

module wave_channel import ch3_pkg::*; (
	input  logic      cery_2mhz,
	input  logic      rst_n,
	input  reg_addr_t addr,
	input  reg_data_t d_in,
	input  logic      apu_wr,
	input  logic      cpu_rd,
	input  logic      len_tick,
	output reg_data_t d_out,
	output logic      rd_valid,
	output logic      ch_on,
	output sample_t   sample_out
);

	logic       wave_cpu_wr, wave_cpu_rd, wave_rd_valid;
	wave_addr_t wave_cpu_addr;
	reg_data_t  wave_wdata, wave_rd_data;
	logic       dac_en, length_en, trigger, len_load;
	volume_t    volume;
	freq_t      freq;
	reg_data_t  len_value;
	logic       fetch_req, nibble_lo, fetch_data_valid;
	wave_addr_t fetch_addr;
	reg_data_t  fetch_data;
	logic       ram_en, ram_we;
	wave_addr_t ram_addr;
	reg_data_t  ram_wdata, ram_rdata;

	ch3_regs i_regs (
		.cery_2mhz     (cery_2mhz),
		.rst_n         (rst_n),
		.addr          (addr),
		.d_in          (d_in),
		.apu_wr        (apu_wr),
		.cpu_rd        (cpu_rd),
		.wave_rd_valid (wave_rd_valid),
		.wave_rd_data  (wave_rd_data),
		.d_out         (d_out),
		.rd_valid      (rd_valid),
		.wave_cpu_wr   (wave_cpu_wr),
		.wave_cpu_rd   (wave_cpu_rd),
		.wave_cpu_addr (wave_cpu_addr),
		.wave_wdata    (wave_wdata),
		.dac_en        (dac_en),
		.volume        (volume),
		.freq          (freq),
		.length_en     (length_en),
		.trigger       (trigger),
		.len_load      (len_load),
		.len_value     (len_value)
	);

	wave_ram_arbiter i_arbiter (
		.cery_2mhz        (cery_2mhz),
		.rst_n            (rst_n),
		.fetch_req        (fetch_req),
		.fetch_addr       (fetch_addr),
		.wave_cpu_wr      (wave_cpu_wr),
		.wave_cpu_rd      (wave_cpu_rd),
		.wave_cpu_addr    (wave_cpu_addr),
		.wave_wdata       (wave_wdata),
		.ram_rdata        (ram_rdata),
		.ram_en           (ram_en),
		.ram_we           (ram_we),
		.ram_addr         (ram_addr),
		.ram_wdata        (ram_wdata),
		.fetch_data_valid (fetch_data_valid),
		.fetch_data       (fetch_data),
		.wave_rd_valid    (wave_rd_valid),
		.wave_rd_data     (wave_rd_data)
	);

	wave_ram i_ram (
		.cery_2mhz (cery_2mhz),
		.en        (ram_en),
		.we        (ram_we),
		.addr      (ram_addr),
		.wdata     (ram_wdata),
		.rdata     (ram_rdata)
	);

	ch3_freq_timer i_timer (
		.cery_2mhz  (cery_2mhz),
		.rst_n      (rst_n),
		.ch_on      (ch_on),
		.trigger    (trigger),
		.freq       (freq),
		.fetch_req  (fetch_req),
		.fetch_addr (fetch_addr),
		.nibble_lo  (nibble_lo)
	);

	ch3_length_ctr i_length (
		.cery_2mhz (cery_2mhz),
		.rst_n     (rst_n),
		.trigger   (trigger),
		.dac_en    (dac_en),
		.length_en (length_en),
		.len_tick  (len_tick),
		.len_load  (len_load),
		.len_value (len_value),
		.ch_on     (ch_on)
	);

	ch3_output i_output (
		.cery_2mhz        (cery_2mhz),
		.rst_n            (rst_n),
		.ch_on            (ch_on),
		.fetch_data_valid (fetch_data_valid),
		.fetch_data       (fetch_data),
		.nibble_lo        (nibble_lo),
		.volume           (volume),
		.sample_out       (sample_out)
	);

endmodule

`default_nettype wire

//--- hdl/wave_ram.sv
`timescale 1ns/1ps
`default_nettype none

module wave_ram import ch3_pkg::*; (
	input  logic       cery_2mhz,
	input  logic       en,
	input  logic       we,
	input  wave_addr_t addr,
	input  reg_data_t  wdata,
	output reg_data_t  rdata
);

	reg_data_t mem [16]; // two samples per byte

	always_ff @(posedge cery_2mhz) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr]; // valid the cycle after en
		end
	end

endmodule

`default_nettype wire

//--- hdl/wave_ram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wave_ram_arbiter import ch3_pkg::*; (
	input  logic       cery_2mhz,
	input  logic       rst_n,
	input  logic       fetch_req,
	input  wave_addr_t fetch_addr,
	input  logic       wave_cpu_wr,
	input  logic       wave_cpu_rd,
	input  wave_addr_t wave_cpu_addr,
	input  reg_data_t  wave_wdata,
	input  reg_data_t  ram_rdata,
	output logic       ram_en,
	output logic       ram_we,
	output wave_addr_t ram_addr,
	output reg_data_t  ram_wdata,
	output logic       fetch_data_valid,
	output reg_data_t  fetch_data,
	output logic       wave_rd_valid,
	output reg_data_t  wave_rd_data
);

	arb_state_t state, state_next;
	logic       cpu_req, pending, cpu_rd_grant, cpu_rd_q;
	logic       def_we;
	wave_addr_t def_addr;
	reg_data_t  def_wdata;

	assign cpu_req = wave_cpu_wr || wave_cpu_rd;
	assign pending = (state == cpu_deferred);

	always_comb begin
		ram_en       = 1'b0;
		ram_we       = 1'b0;
		ram_addr     = fetch_addr;
		ram_wdata    = wave_wdata;
		cpu_rd_grant = 1'b0;
		state_next   = idle;
		if (fetch_req) begin // playback has fixed priority
			ram_en     = 1'b1;
			state_next = (cpu_req || pending) ? cpu_deferred : fetch;
		end else if (pending) begin
			ram_en       = 1'b1;
			ram_we       = def_we;
			ram_addr     = def_addr;
			ram_wdata    = def_wdata;
			cpu_rd_grant = !def_we;
		end else if (cpu_req) begin
			ram_en       = 1'b1;
			ram_we       = wave_cpu_wr;
			ram_addr     = wave_cpu_addr;
			cpu_rd_grant = wave_cpu_rd;
		end
	end

	always_ff @(posedge cery_2mhz) begin
		if (!rst_n) begin
			state    <= idle;
			cpu_rd_q <= 1'b0;
		end else begin
			state    <= state_next;
			cpu_rd_q <= cpu_rd_grant;
		end
	end

	// hold the losing cpu access
	always_ff @(posedge cery_2mhz) begin
		if (fetch_req && cpu_req) begin
			def_we    <= wave_cpu_wr;
			def_addr  <= wave_cpu_addr;
			def_wdata <= wave_wdata;
		end
	end

	// both non-idle states mean a fetch went out last cycle
	assign fetch_data_valid = (state != idle);
	assign fetch_data       = ram_rdata;
	assign wave_rd_valid    = cpu_rd_q;
	assign wave_rd_data     = ram_rdata;

endmodule

`default_nettype wire

//--- sources.f
+incdir+hdl
hdl/ch3_pkg.sv
hdl/ch3_regs.sv
hdl/wave_ram_arbiter.sv
hdl/wave_ram.sv
hdl/ch3_freq_timer.sv
hdl/ch3_length_ctr.sv
hdl/ch3_output.sv
hdl/wave_channel.sv
test/tb_clk_gen.sv
test/wave_channel_sva.sv
test/tb_wave_channel.sv

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- test/tb_wave_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "ch3_cfg.svh"

module tb_wave_channel import ch3_pkg::*; ();

	logic      cery_2mhz, rst_n;
	reg_addr_t addr;
	reg_data_t d_in, d_out;
	logic      apu_wr, cpu_rd, len_tick, rd_valid, ch_on;
	sample_t   sample_out;

	int        value_errors = 0;
	int        timeout_errors = 0;
	reg_data_t wave_ref [16]; // expected wave ram contents
	logic      dac_ref, len_en_ref;
	volume_t   vol_ref;

	tb_clk_gen i_clk (.clk(cery_2mhz), .rst_n(rst_n));

	wave_channel i_dut (
		.cery_2mhz  (cery_2mhz),
		.rst_n      (rst_n),
		.addr       (addr),
		.d_in       (d_in),
		.apu_wr     (apu_wr),
		.cpu_rd     (cpu_rd),
		.len_tick   (len_tick),
		.d_out      (d_out),
		.rd_valid   (rd_valid),
		.ch_on      (ch_on),
		.sample_out (sample_out)
	);

	task automatic check_value(input string name, input reg_data_t exp, input reg_data_t act);
		assert (exp == act) else begin
			value_errors++;
			$display("** Error %s: expected 0x%02h, actual 0x%02h", name, exp, act);
		end
	endtask

	task automatic cpu_write(input reg_addr_t a, input reg_data_t d);
		@(posedge cery_2mhz);
		addr   <= a;
		d_in   <= d;
		apu_wr <= 1'b1;
		@(posedge cery_2mhz);
		apu_wr <= 1'b0; // sampled high on this edge
	endtask

	task automatic cpu_read(input reg_addr_t a, output reg_data_t d);
		int n;
		@(posedge cery_2mhz);
		addr   <= a;
		cpu_rd <= 1'b1;
		@(posedge cery_2mhz);
		cpu_rd <= 1'b0;
		n = 0;
		do begin
			@(negedge cery_2mhz);
			n++;
		end while (!rd_valid && n < 8);
		if (!rd_valid) begin
			timeout_errors++;
			$display("no read data from address 0x%02h within %0d cycles", a, n);
		end
		d = d_out;
	endtask

	task automatic wait_ch_on(input logic level, input string name);
		int n;
		n = 0;
		do begin
			@(negedge cery_2mhz);
			n++;
		end while (ch_on !== level && n < 20);
		if (ch_on !== level) begin
			timeout_errors++;
			$display("%s: ch_on never became %0b within %0d cycles", name, level, n);
		end
	endtask

	task automatic pulse_len_tick();
		@(posedge cery_2mhz);
		len_tick <= 1'b1;
		@(posedge cery_2mhz);
		len_tick <= 1'b0;
	endtask

	function automatic reg_data_t reg_expect(input reg_addr_t a);
		reg_data_t e;
		e = 8'hFF; // unused bits read as 1
		if (a == `CH3_NR30)
			e[7] = dac_ref;
		if (a == `CH3_NR32)
			e[6:5] = vol_ref;
		if (a == `CH3_NR34)
			e[6] = len_en_ref;
		return e;
	endfunction

	function automatic sample_t sample_expect(input int p, input volume_t v);
		wave_pos_t pos;
		sample_t   nib;
		pos = wave_pos_t'(p); // wraps at 32
		nib = pos[0] ? wave_ref[pos[4:1]][3:0] : wave_ref[pos[4:1]][7:4];
		return (v == 2'd0) ? 4'h0 : nib >> (v - 2'd1);
	endfunction

	task automatic start_playback(input volume_t v, input freq_t f);
		cpu_write(`CH3_NR32, {1'b0, v, 5'h00});
		cpu_write(`CH3_NR33, f[7:0]);
		cpu_write(`CH3_NR30, 8'h80);
		cpu_write(`CH3_NR34, {5'b10000, f[10:8]}); // trigger, length off
		wait_ch_on(1'b1, "play_start");
	endtask

	// sample p shows up 2 + p * period cycles after ch_on rises
	task automatic check_playback(input volume_t v, input int k);
		int period, cyc, p;
		period = k + 1;
		start_playback(v, freq_t'(`CH3_TIMER_MAX - k));
		cyc = 0;
		p = 1;
		while (p <= 40) begin
			@(negedge cery_2mhz);
			cyc++;
			if (cyc == 2 + p * period + period / 2) begin // mid sample
				check_value("playback", 8'(sample_expect(p, v)), 8'(sample_out));
				p++;
			end
		end
		cpu_write(`CH3_NR30, 8'h00);
		wait_ch_on(1'b0, "play_stop");
	endtask

	initial begin
		int        n, n_ticks;
		reg_data_t d, got, len_l;
		reg_addr_t a;
		addr     = '0;
		d_in     = '0;
		apu_wr   = 1'b0;
		cpu_rd   = 1'b0;
		len_tick = 1'b0;
		void'($urandom(32'h7996));
		n = 0;
		do begin
			@(negedge cery_2mhz);
			n++;
		end while (!rst_n && n < 10);
		if (!rst_n) begin
			timeout_errors++;
			$display("reset still asserted after %0d cycles", n);
		end

		for (int r = 0; r < 8; r++) begin // register read-back
			d = reg_data_t'($urandom);
			dac_ref = d[7];
			cpu_write(`CH3_NR30, d);
			cpu_write(`CH3_NR31, reg_data_t'($urandom));
			d = reg_data_t'($urandom);
			vol_ref = d[6:5];
			cpu_write(`CH3_NR32, d);
			cpu_write(`CH3_NR33, reg_data_t'($urandom));
			d = reg_data_t'($urandom) & 8'h7F; // no trigger here
			len_en_ref = d[6];
			cpu_write(`CH3_NR34, d);
			for (int j = 0; j < 7; j++) begin // 0x1A..0x20
				a = 8'h1A + 8'(j);
				cpu_read(a, got);
				check_value("reg_readback", reg_expect(a), got);
			end
		end

		cpu_write(`CH3_NR30, 8'h00);
		for (int i = 0; i < 16; i++) begin
			wave_ref[i[3:0]] = reg_data_t'($urandom);
			cpu_write(`CH3_WAVE_BASE | 8'(i), wave_ref[i[3:0]]);
		end
		for (int i = 0; i < 16; i++) begin
			cpu_read(`CH3_WAVE_BASE | 8'(i), got);
			check_value("wave_readback", wave_ref[i[3:0]], got);
		end

		cpu_write(`CH3_NR34, 8'h80); // trigger with dac off
		repeat (3) @(negedge cery_2mhz);
		check_value("trigger_dac_off", 8'h00, 8'(ch_on));
		cpu_write(`CH3_NR30, 8'h80);
		cpu_write(`CH3_NR34, 8'h80);
		wait_ch_on(1'b1, "trigger_dac_on");
		cpu_write(`CH3_NR30, 8'h00);
		wait_ch_on(1'b0, "dac_clear");

		len_l = reg_data_t'($urandom);
		n_ticks = 256 - int'(len_l);
		cpu_write(`CH3_NR30, 8'h80);
		cpu_write(`CH3_NR31, len_l);
		cpu_write(`CH3_NR34, 8'hC0); // trigger with length enabled
		wait_ch_on(1'b1, "length_start");
		for (int t = 1; t <= n_ticks; t++) begin
			pulse_len_tick();
			repeat (2) @(negedge cery_2mhz); // count, then ch_on
			check_value("length_expiry", (t < n_ticks) ? 8'h01 : 8'h00, 8'(ch_on));
		end

		for (int v = 0; v < 4; v++)
			check_playback(volume_t'(v), 15);

		start_playback(2'd1, freq_t'(`CH3_TIMER_MAX - 3)); // fetch every 4 cycles
		for (int i = 0; i < 16; i++) begin
			wave_ref[i[3:0]] = reg_data_t'($urandom);
			repeat ($urandom % 4) @(posedge cery_2mhz);
			cpu_write(`CH3_WAVE_BASE | 8'(i), wave_ref[i[3:0]]);
		end
		check_value("busy_playing", 8'h01, 8'(ch_on));
		cpu_write(`CH3_NR30, 8'h00);
		wait_ch_on(1'b0, "busy_stop");
		for (int i = 0; i < 16; i++) begin
			cpu_read(`CH3_WAVE_BASE | 8'(i), got);
			check_value("busy_write", wave_ref[i[3:0]], got);
		end

		$display("value errors: %0d, timeouts: %0d, assertion failures: %0d",
			value_errors, timeout_errors, i_dut.i_sva.fail_cnt);
		if (value_errors + timeout_errors + i_dut.i_sva.fail_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/wave_channel_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "ch3_cfg.svh"

module wave_channel_sva import ch3_pkg::*; (
	input logic      cery_2mhz,
	input logic      rst_n,
	input reg_addr_t addr,
	input reg_data_t d_in,
	input logic      apu_wr,
	input logic      rd_valid,
	input logic      ch_on,
	input sample_t   sample_out
);

	int   fail_cnt = 0;
	logic dac_clear;

	assign dac_clear = apu_wr && (addr == `CH3_NR30) && !d_in[7]; // NR30 write with dac off

	rd_valid_single: assert property (@(posedge cery_2mhz) disable iff (!rst_n)
		rd_valid |=> !rd_valid)
	else begin
		$error("rd_valid stayed high for two cycles");
		fail_cnt++;
	end

	// dac_en drops after the write edge, ch_on one edge later
	dac_off_kills_channel: assert property (@(posedge cery_2mhz) disable iff (!rst_n)
		$past(dac_clear, 2) |-> !ch_on)
	else begin
		$error("ch_on still high after NR30 cleared the dac");
		fail_cnt++;
	end

	silent_when_off: assert property (@(posedge cery_2mhz) disable iff (!rst_n)
		!ch_on |-> sample_out == '0)
	else begin
		$error("sample_out not zero while ch_on is low");
		fail_cnt++;
	end

endmodule

bind wave_channel wave_channel_sva i_sva (
	.cery_2mhz  (cery_2mhz),
	.rst_n      (rst_n),
	.addr       (addr),
	.d_in       (d_in),
	.apu_wr     (apu_wr),
	.rd_valid   (rd_valid),
	.ch_on      (ch_on),
	.sample_out (sample_out)
);

`default_nettype wire
